/* common/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus widths
`define SOC_ADDR_W       32
`define SOC_DATA_W       32

// program/data ram, 8192 words at byte address bits 14:2
`define RAM_WORD_ADDR_W  13
// text buffer, 512 words at bits 10:2, four cells packed per word
`define TXT_WORD_ADDR_W  9

// address bit that steers an access to the text buffer
`define VGA_SEL_BIT      16

// text geometry, cells are solid blocks
`define TEXT_COLS        80
`define TEXT_ROWS        25
`define CELL_W           8
`define CELL_H           16

// horizontal timing in pixels
`define H_ACTIVE         (`TEXT_COLS * `CELL_W)
`define H_FRONT          16
`define H_SYNC           96
`define H_BACK           48

// vertical timing in lines
`define V_ACTIVE         (`TEXT_ROWS * `CELL_H)
`define V_FRONT          12
`define V_SYNC           2
`define V_BACK           35

`endif

/* common/soc_pkg.sv */
`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

   // bus payload types
   typedef logic [`SOC_ADDR_W-1:0]   addr_t;
   typedef logic [`SOC_DATA_W-1:0]   data_t;
   typedef logic [`SOC_DATA_W/8-1:0] strb_t;

   // axi response codes, only okay is ever returned
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_exokay = 2'b01,
      resp_slverr = 2'b10,
      resp_decerr = 2'b11
   } axi_resp_e;

   // axi to sram bridge states
   typedef enum logic [2:0] {st_idle, st_wr, st_bresp, st_rd, st_rresp} bridge_state_e;

   // decoder targets
   typedef enum logic {sel_ram, sel_text} slave_sel_e;

endpackage

`default_nettype wire

/* common/sram_if.sv */
`timescale 1ns/100ps
`default_nettype none

// sram style strobe port, no handshake
// rdata is valid the cycle after ren
interface sram_if import soc_pkg::*; ();

   addr_t raddr;
   logic  ren;
   data_t rdata;
   addr_t waddr;
   data_t wdata;
   // per byte write enables, zero means no write
   strb_t wen;

   modport master (output raddr, ren, waddr, wdata, wen, input rdata);
   modport slave  (input raddr, ren, waddr, wdata, wen, output rdata);

endinterface

`default_nettype wire

/* hw/axi_sram_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_sram_bridge import soc_pkg::*; (
   input  wire        clk,
   input  wire        arst_n,

   // write address
   input  wire addr_t awaddr,
   input  wire        awvalid,
   output logic       awready,
   // write data
   input  wire data_t wdata,
   input  wire strb_t wstrb,
   input  wire        wvalid,
   output logic       wready,
   // write response
   output axi_resp_e  bresp,
   output logic       bvalid,
   input  wire        bready,
   // read address
   input  wire addr_t araddr,
   input  wire        arvalid,
   output logic       arready,
   // read data
   output data_t      rdata,
   output axi_resp_e  rresp,
   output logic       rvalid,
   input  wire        rready,

   sram_if.master     mem
);

   bridge_state_e state;
   logic          ar_hs;
   logic          aw_hs;

   // captured request
   addr_t addr_q;
   data_t wdata_q;
   strb_t wstrb_q;

   // only accept in idle, so a held response blocks new requests
   assign arready = (state == st_idle);
   // aw and w taken together, and a waiting read goes first
   assign awready = (state == st_idle) && awvalid && wvalid && !arvalid;
   assign wready  = awready;

   assign ar_hs = arvalid && arready;
   assign aw_hs = awvalid && awready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= st_idle;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (ar_hs) begin
                  state <= st_rd;
               end else if (aw_hs) begin
                  state <= st_wr;
               end
            end
            // one strobe cycle each
            st_rd: state <= st_rresp;
            st_wr: state <= st_bresp;
            st_rresp: begin
               // first cycle here the sram data is on the bus
               if (!rvalid) begin
                  rvalid <= 1'b1;
               end else if (rready) begin
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            st_bresp: begin
               if (!bvalid) begin
                  bvalid <= 1'b1;
               end else if (bready) begin
                  bvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         addr_q <= araddr;
      end else if (aw_hs) begin
         addr_q  <= awaddr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
      // grab read data once, then hold it while rvalid waits
      if (state == st_rresp && !rvalid) begin
         rdata <= mem.rdata;
      end
   end

   // sram side
   assign mem.raddr = addr_q;
   assign mem.waddr = addr_q;
   assign mem.wdata = wdata_q;
   assign mem.ren   = (state == st_rd);
   assign mem.wen   = (state == st_wr) ? wstrb_q : '0;

   // no error paths
   assign bresp = resp_okay;
   assign rresp = resp_okay;

endmodule

`default_nettype wire

/* hw/ram_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module ram_bridge import soc_pkg::*; (
   input  wire     clk,
   input  wire     arst_n,
   sram_if.slave   cpu,
   sram_if.master  ram_port,
   sram_if.master  text_port
);

   slave_sel_e rd_sel;
   slave_sel_e wr_sel;
   // target of the read that is returning now
   slave_sel_e rd_sel_q;

   // one address bit picks the target
   assign rd_sel = cpu.raddr[`VGA_SEL_BIT] ? sel_text : sel_ram;
   assign wr_sel = cpu.waddr[`VGA_SEL_BIT] ? sel_text : sel_ram;

   // address and data go to both sides
   assign ram_port.raddr  = cpu.raddr;
   assign ram_port.waddr  = cpu.waddr;
   assign ram_port.wdata  = cpu.wdata;
   assign text_port.raddr = cpu.raddr;
   assign text_port.waddr = cpu.waddr;
   assign text_port.wdata = cpu.wdata;

   // strobes only reach the selected side
   assign ram_port.ren  = cpu.ren && (rd_sel == sel_ram);
   assign text_port.ren = cpu.ren && (rd_sel == sel_text);
   assign ram_port.wen  = (wr_sel == sel_ram) ? cpu.wen : '0;
   assign text_port.wen = (wr_sel == sel_text) ? cpu.wen : '0;

   // remember where the read went, data comes back a cycle later
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_sel_q <= sel_ram;
      end else if (cpu.ren) begin
         rd_sel_q <= rd_sel;
      end
   end

   assign cpu.rdata = (rd_sel_q == sel_text) ? text_port.rdata : ram_port.rdata;

endmodule

`default_nettype wire

/* hw/sram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module sram import soc_pkg::*; (
   input  wire    clk,
   sram_if.slave  port
);

   localparam int DEPTH = 2 ** `RAM_WORD_ADDR_W;

   data_t mem [0:DEPTH-1];

   logic [`RAM_WORD_ADDR_W-1:0] waddr;
   logic [`RAM_WORD_ADDR_W-1:0] raddr;

   // byte address to word address
   assign waddr = port.waddr[`RAM_WORD_ADDR_W+1:2];
   assign raddr = port.raddr[`RAM_WORD_ADDR_W+1:2];

   always_ff @(posedge clk) begin
      // write only the enabled lanes
      for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
         if (port.wen[b]) begin
            mem[waddr][8*b +: 8] <= port.wdata[8*b +: 8];
         end
      end
      // read holds until the next ren
      if (port.ren) begin
         port.rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

/* text_vga/vga_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module vga_timing (
   input  wire        clk,
   input  wire        arst_n,
   output logic [9:0] h_count,
   output logic [9:0] v_count,
   output logic       active,
   output logic       hsync_n,
   output logic       vsync_n
);

   localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
   // sync windows follow the front porch
   localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
   localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;

   // one pixel per clock, line count steps at end of line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_count <= '0;
         v_count <= '0;
      end else if (h_count == 10'(H_TOTAL - 1)) begin
         h_count <= '0;
         if (v_count == 10'(V_TOTAL - 1)) begin
            v_count <= '0;
         end else begin
            v_count <= v_count + 10'd1;
         end
      end else begin
         h_count <= h_count + 10'd1;
      end
   end

   // active low syncs
   assign hsync_n = !((h_count >= 10'(H_SYNC_START)) &&
                      (h_count <  10'(H_SYNC_START + `H_SYNC)));
   assign vsync_n = !((v_count >= 10'(V_SYNC_START)) &&
                      (v_count <  10'(V_SYNC_START + `V_SYNC)));

   assign active = (h_count < 10'(`H_ACTIVE)) && (v_count < 10'(`V_ACTIVE));

endmodule

`default_nettype wire

/* text_vga/text80x25.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module text80x25 import soc_pkg::*; (
   input  wire        clk,
   input  wire        arst_n,
   sram_if.slave      host,
   output logic [2:0] vga_rgb,
   output logic       vga_hsync,
   output logic       vga_vsync
);

   localparam int DEPTH  = 2 ** `TXT_WORD_ADDR_W;
   localparam int COL_SH = $clog2(`CELL_W);
   localparam int ROW_SH = $clog2(`CELL_H);
   localparam int IDX_W  = 12;

   data_t text_mem [0:DEPTH-1];

   // stage 0, straight off the counters
   logic [9:0]            h_count;
   logic [9:0]            v_count;
   logic                  active;
   logic                  hsync_n;
   logic                  vsync_n;
   logic [9-COL_SH:0]     col;
   logic [9-ROW_SH:0]     row;
   logic [IDX_W-1:0]      cell_idx;
   logic [`TXT_WORD_ADDR_W-1:0] scan_addr;
   logic [`TXT_WORD_ADDR_W-1:0] host_addr;

   // stage 1, buffer word and matching controls
   data_t      scan_word;
   logic [1:0] byte_sel_q;
   logic       active_q;
   logic       hsync_q;
   logic       vsync_q;
   logic [7:0] cell_byte;

   vga_timing u_timing (
      .clk     (clk     ),
      .arst_n  (arst_n  ),
      .h_count (h_count ),
      .v_count (v_count ),
      .active  (active  ),
      .hsync_n (hsync_n ),
      .vsync_n (vsync_n )
   );

   // pixel to cell, index = row * 80 + col
   assign col      = h_count[9:COL_SH];
   assign row      = v_count[9:ROW_SH];
   assign cell_idx = IDX_W'(row) * IDX_W'(`TEXT_COLS) + IDX_W'(col);
   // four cells per word, index wraps off screen but rgb is blanked there
   assign scan_addr = cell_idx[`TXT_WORD_ADDR_W+1:2];
   assign host_addr = host.waddr[`TXT_WORD_ADDR_W+1:2];

   // buffer is write only from the bus
   assign host.rdata = '0;

   always_ff @(posedge clk) begin
      for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
         if (host.wen[b]) begin
            text_mem[host_addr][8*b +: 8] <= host.wdata[8*b +: 8];
         end
      end
      scan_word <= text_mem[scan_addr];
   end

   assign cell_byte = scan_word[8*byte_sel_q +: 8];

   // both stages carry the syncs so they stay lined up with rgb
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         byte_sel_q <= 2'd0;
         active_q   <= 1'b0;
         hsync_q    <= 1'b1;
         vsync_q    <= 1'b1;
         vga_rgb    <= 3'd0;
         vga_hsync  <= 1'b1;
         vga_vsync  <= 1'b1;
      end else begin
         byte_sel_q <= cell_idx[1:0];
         active_q   <= active;
         hsync_q    <= hsync_n;
         vsync_q    <= vsync_n;
         // colour is the low bits of the cell byte
         vga_rgb    <= active_q ? cell_byte[2:0] : 3'd0;
         vga_hsync  <= hsync_q;
         vga_vsync  <= vsync_q;
      end
   end

endmodule

`default_nettype wire

/* hw/soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; (
   input  wire        clk,
   input  wire        arst_n,

   input  wire addr_t awaddr,
   input  wire        awvalid,
   output logic       awready,
   input  wire data_t wdata,
   input  wire strb_t wstrb,
   input  wire        wvalid,
   output logic       wready,
   output axi_resp_e  bresp,
   output logic       bvalid,
   input  wire        bready,
   input  wire addr_t araddr,
   input  wire        arvalid,
   output logic       arready,
   output data_t      rdata,
   output axi_resp_e  rresp,
   output logic       rvalid,
   input  wire        rready,

   output logic [2:0] vga_rgb,
   output logic       vga_hsync,
   output logic       vga_vsync
);

   // bus side, then one port per target
   sram_if cpu_ram ();
   sram_if ram_port ();
   sram_if text_port ();

   axi_sram_bridge u_axi_sram_bridge (
      .clk     (clk       ),
      .arst_n  (arst_n    ),
      .awaddr  (awaddr    ),
      .awvalid (awvalid   ),
      .awready (awready   ),
      .wdata   (wdata     ),
      .wstrb   (wstrb     ),
      .wvalid  (wvalid    ),
      .wready  (wready    ),
      .bresp   (bresp     ),
      .bvalid  (bvalid    ),
      .bready  (bready    ),
      .araddr  (araddr    ),
      .arvalid (arvalid   ),
      .arready (arready   ),
      .rdata   (rdata     ),
      .rresp   (rresp     ),
      .rvalid  (rvalid    ),
      .rready  (rready    ),
      .mem     (cpu_ram   )
   );

   ram_bridge u_ram_bridge (
      .clk       (clk       ),
      .arst_n    (arst_n    ),
      .cpu       (cpu_ram   ),
      .ram_port  (ram_port  ),
      .text_port (text_port )
   );

   sram u_ram (
      .clk  (clk      ),
      .port (ram_port )
   );

   text80x25 u_text (
      .clk       (clk       ),
      .arst_n    (arst_n    ),
      .host      (text_port ),
      .vga_rgb   (vga_rgb   ),
      .vga_hsync (vga_hsync ),
      .vga_vsync (vga_vsync )
   );

endmodule

`default_nettype wire

/* verif/tb_soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module tb_soc_top import soc_pkg::*; ();

   localparam int H_TOTAL  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int V_TOTAL  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
   // four frames of scan plus slack for the bus tests
   localparam int WATCHDOG_CYCLES = 4 * H_TOTAL * V_TOTAL + 20000;
   // valid rises just after the second edge past the handshake
   localparam int RESP_EDGES = 3;
   localparam addr_t TXT_BASE = addr_t'(1) << `VGA_SEL_BIT;
   localparam int HSYNC = 0;
   localparam int VSYNC = 1;

   logic      clk;
   logic      arst_n;
   addr_t     awaddr;
   logic      awvalid;
   logic      awready;
   data_t     wdata;
   strb_t     wstrb;
   logic      wvalid;
   logic      wready;
   axi_resp_e bresp;
   logic      bvalid;
   logic      bready;
   addr_t     araddr;
   logic      arvalid;
   logic      arready;
   data_t     rdata;
   axi_resp_e rresp;
   logic      rvalid;
   logic      rready;
   logic [2:0] vga_rgb;
   logic      vga_hsync;
   logic      vga_vsync;

   string cur_test;
   int    errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;

   // ram words under test and their expected contents
   addr_t test_addr [8];
   data_t ram_model [8];

   soc_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic end_test(input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s done, ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s done, %0d errors", cur_test, errors - errs_before);
      end
   endtask

   // axi byte strobe rule, lanes with a set strobe take the new byte
   function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = nw[8*b +: 8];
         end
      end
      return res;
   endfunction

   // single beat write, bready held low for hold cycles once bvalid shows
   task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int hold, output axi_resp_e resp, output int lat);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b0;
      @(posedge clk);
      while (!(awready && wready)) begin
         @(posedge clk);
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!bvalid);
      resp = bresp;
      // another write is offered while the response waits
      repeat (hold) begin
         awvalid <= 1'b1;
         wvalid  <= 1'b1;
         @(posedge clk);
         check("bvalid held", 32'd1, 32'(bvalid));
         check("arready blocked", 32'd0, 32'(arready));
         check("awready blocked", 32'd0, 32'(awready));
         check("wready blocked", 32'd0, 32'(wready));
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   // single beat read, rdata must not move while rready is low
   task automatic axi_read(input addr_t addr, input int hold, output data_t data,
                           output axi_resp_e resp, output int lat);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b0;
      @(posedge clk);
      while (!arready) begin
         @(posedge clk);
      end
      arvalid <= 1'b0;
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!rvalid);
      data = rdata;
      resp = rresp;
      // a write is offered while the read data waits
      repeat (hold) begin
         awvalid <= 1'b1;
         wvalid  <= 1'b1;
         @(posedge clk);
         check("rvalid held", 32'd1, 32'(rvalid));
         check("rdata stable", data, rdata);
         check("arready blocked", 32'd0, 32'(arready));
         check("awready blocked", 32'd0, 32'(awready));
         check("wready blocked", 32'd0, 32'(wready));
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      rready  <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   function automatic logic sync_level(input int which);
      return (which == HSYNC) ? vga_hsync : vga_vsync;
   endfunction

   // edges until the chosen sync is sampled at level
   task automatic cycles_until(input int which, input logic level, output int n);
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (sync_level(which) !== level);
   endtask

   task automatic check_idle_outputs();
      check("bvalid", 32'd0, 32'(bvalid));
      check("rvalid", 32'd0, 32'(rvalid));
      check("arready", 32'd1, 32'(arready));
      check("hsync", 32'd1, 32'(vga_hsync));
      check("vsync", 32'd1, 32'(vga_vsync));
      check("rgb", 32'd0, 32'(vga_rgb));
   endtask

   task automatic test_reset();
      int errs;
      errs = errors;
      cur_test = "reset";
      // first edge applies the reset
      @(posedge clk);
      repeat (4) begin
         @(posedge clk);
         check_idle_outputs();
      end
      arst_n <= 1'b1;
      @(posedge clk);
      check_idle_outputs();
      end_test(errs);
   endtask

   task automatic test_ram_rw();
      int        errs;
      int        lat;
      data_t     d;
      data_t     got;
      strb_t     s;
      axi_resp_e resp;
      errs = errors;
      cur_test = "ram_rw";
      // distinct word addresses, bits 14:2 only
      for (int i = 0; i < 8; i++) begin
         test_addr[i] = addr_t'((($urandom % 1024) * 8 + i) * 4);
         d = $urandom;
         axi_write(test_addr[i], d, 4'hf, 0, resp, lat);
         ram_model[i] = d;
         check("bresp", 32'(resp_okay), 32'(resp));
         check("b latency", RESP_EDGES, lat);
      end
      // partial overwrite of every other word
      for (int i = 0; i < 8; i += 2) begin
         d = $urandom;
         s = strb_t'($urandom % 15 + 1);
         axi_write(test_addr[i], d, s, 0, resp, lat);
         ram_model[i] = merge_bytes(ram_model[i], d, s);
         check("bresp", 32'(resp_okay), 32'(resp));
      end
      for (int i = 0; i < 8; i++) begin
         axi_read(test_addr[i], 0, got, resp, lat);
         check("rdata", ram_model[i], got);
         check("rresp", 32'(resp_okay), 32'(resp));
         check("r latency", RESP_EDGES, lat);
      end
      end_test(errs);
   endtask

   task automatic test_backpressure();
      int        errs;
      int        lat;
      data_t     d;
      data_t     got;
      axi_resp_e resp;
      errs = errors;
      cur_test = "backpressure";
      d = $urandom;
      axi_write(test_addr[1], d, 4'hf, int'($urandom % 16) + 1, resp, lat);
      ram_model[1] = d;
      check("bresp", 32'(resp_okay), 32'(resp));
      axi_read(test_addr[1], int'($urandom % 16) + 1, got, resp, lat);
      check("rdata", ram_model[1], got);
      check("rresp", 32'(resp_okay), 32'(resp));
      end_test(errs);
   endtask

   task automatic test_decode();
      int        errs;
      int        lat;
      data_t     got;
      axi_resp_e resp;
      errs = errors;
      cur_test = "addr_decode";
      // text side reads back as zero
      axi_read(test_addr[3] | TXT_BASE, 0, got, resp, lat);
      check("text rdata", 32'd0, got);
      // same low offset in the text region must not touch the ram word
      axi_write(test_addr[3] | TXT_BASE, $urandom, 4'hf, 0, resp, lat);
      axi_read(test_addr[3], 0, got, resp, lat);
      check("ram word kept", ram_model[3], got);
      end_test(errs);
   endtask

   task automatic test_sync_timing();
      int errs;
      int n;
      int low;
      int high;
      errs = errors;
      cur_test = "sync_timing";
      cycles_until(HSYNC, 1'b1, n);
      cycles_until(HSYNC, 1'b0, n);
      cycles_until(HSYNC, 1'b1, low);
      cycles_until(HSYNC, 1'b0, high);
      check("hsync low", `H_SYNC, low);
      check("hsync period", H_TOTAL, low + high);
      cycles_until(VSYNC, 1'b1, n);
      cycles_until(VSYNC, 1'b0, n);
      cycles_until(VSYNC, 1'b1, low);
      cycles_until(VSYNC, 1'b0, high);
      check("vsync low", `V_SYNC * H_TOTAL, low);
      check("vsync period", V_TOTAL * H_TOTAL, low + high);
      end_test(errs);
   endtask

   task automatic test_text_render();
      int        errs;
      int        n;
      int        lat;
      int        idx;
      int        lane;
      int        line;
      int        x;
      int        y;
      int        cell_row [5];
      int        cell_col [5];
      logic [2:0] colour [5];
      data_t     d;
      strb_t     s;
      axi_resp_e resp;
      errs = errors;
      cur_test = "text_render";
      // rows ascending so one frame covers them all, last cell at 79,24
      cell_row = '{0, 6, 13, 19, 24};
      cell_col = '{0, 41, 7, 66, 79};
      for (int i = 0; i < 5; i++) begin
         idx  = cell_row[i] * `TEXT_COLS + cell_col[i];
         lane = idx % 4;
         d    = $urandom;
         d[8*lane +: 3] = 3'((i % 7) + 1);
         s = (i == 4) ? strb_t'(4'hf) : strb_t'(1 << lane);
         axi_write(TXT_BASE | addr_t'((idx / 4) * 4), d, s, 0, resp, lat);
         colour[i] = d[8*lane +: 3];
      end
      // frame start is the vsync rise
      cycles_until(VSYNC, 1'b0, n);
      cycles_until(VSYNC, 1'b1, n);
      line = 0;
      for (int i = 0; i < 5; i++) begin
         // centre pixel of the cell
         y = cell_row[i] * `CELL_H + `CELL_H / 2;
         x = cell_col[i] * `CELL_W + `CELL_W / 2;
         while (line < `V_BACK + y + 1) begin
            cycles_until(HSYNC, 1'b0, n);
            cycles_until(HSYNC, 1'b1, n);
            line++;
         end
         repeat (`H_BACK + x) @(posedge clk);
         check($sformatf("rgb cell %0d,%0d", cell_col[i], cell_row[i]),
               32'(colour[i]), 32'(vga_rgb));
      end
      // next line, middle of the front porch
      cycles_until(HSYNC, 1'b0, n);
      cycles_until(HSYNC, 1'b1, n);
      repeat (`H_BACK + `H_ACTIVE + `H_FRONT / 2) @(posedge clk);
      check("rgb front porch", 32'd0, 32'(vga_rgb));
      end_test(errs);
   endtask

   initial begin
      arst_n  <= 1'b0;
      awaddr  <= '0;
      awvalid <= 1'b0;
      wdata   <= '0;
      wstrb   <= '0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      araddr  <= '0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      void'($urandom(32'h0cfd_eac1));
      test_reset();
      test_ram_rw();
      test_backpressure();
      test_decode();
      test_sync_timing();
      test_text_render();
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* soc_text.f */
+incdir+common
common/soc_pkg.sv
common/sram_if.sv
hw/axi_sram_bridge.sv
hw/ram_bridge.sv
hw/sram.sv
text_vga/vga_timing.sv
text_vga/text80x25.sv
hw/soc_top.sv
verif/tb_soc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f soc_text.f --top-module tb_soc_top \
   --Mdir "$BUILD_DIR" -o sim_soc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_soc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
